// ==== files.f ====
+incdir+.
pcie_wr_pkg.sv
rx_in_reg.sv
tlp_hdr_decode.sv
tlp_wr_fsm.sv
wr_lane_steer.sv
pcie_rx_wr_top.sv
tb_pcie_rx_wr.sv

// ==== Makefile ====
TOP  = tb_pcie_rx_wr
SRCS = $(shell grep -v '^+' files.f) tb_tlp_model.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	$(BIN) > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_tlp_model.svh ====
/* write TLP model: builds a memory-write TLP, drives its beats on the
   receive bus and queues the lane writes the handler should make */
`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

// payload is big endian on the wire
function automatic logic [dw_w-1:0] reverse_bytes(input logic [dw_w-1:0] d);
   logic [dw_w-1:0] r;
   for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = d[8*(3-b) +: 8];
   end
   return r;
endfunction

task automatic push_expected(input logic [mem_sel_w-1:0] sel, input logic [31:0] a,
                             input logic [dw_w-1:0] d, input logic [be_w-1:0] m);
   wr_rec_t rec;
   rec.sel  = sel;
   rec.addr = a[addr_bits-1:0];
   rec.data = reverse_bytes(d);
   rec.mask = m;
   if (a[2]) begin
      hi_q.push_back(rec);
   end else begin
      lo_q.push_back(rec);
   end
endtask

task automatic drive_beat(input logic [trn_data_w-1:0] data, input logic sof,
                          input logic eof, input logic [7:0] rem_n,
                          input logic [6:0] bar_hit_n, input logic ready,
                          input logic poisoned);
   trn_rd         = data;
   trn_rsof_n     = ~sof;
   trn_reof_n     = ~eof;
   trn_rrem_n     = rem_n;
   trn_rbar_hit_n = bar_hit_n;
   trn_rsrc_rdy_n = ~ready;
   trn_rerrfwd_n  = ~poisoned;
   @(posedge pcie_clk);
   #drive_delay;
endtask

task automatic idle_cycles(input int n);
   repeat (n) drive_beat('0, 1'b0, 1'b0, 8'h00, hit_none, 1'b0, 1'b0);
endtask

task automatic send_tlp(input logic [1:0] fmt, input logic [4:0] tlp_type,
                        input logic [6:0] bar_hit_n, input logic [31:0] addr, input int len,
                        input logic [be_w-1:0] first_be, input logic [be_w-1:0] last_be,
                        input int gap_mode);
   logic [trn_data_w-1:0] head;
   logic [trn_data_w-1:0] beats[$];
   logic [trn_data_w-1:0] junk;
   logic [dw_w-1:0]       dws[$];
   logic [dw_w-1:0]       filler;
   logic [be_w-1:0]       mask;
   logic [mem_sel_w-1:0]  sel;
   logic [7:0]            rem_n;
   logic                  is_4dw;
   logic                  is_wr;
   logic                  single;
   int                    k;
   int                    last;

   is_4dw = (fmt == fmt_4dw_wr);
   is_wr  = (fmt == fmt_3dw_wr || is_4dw) && (tlp_type == type_mem) &&
            (!bar_hit_n[bar0_hit_idx] || !bar_hit_n[bar2_hit_idx]);
   for (int i = 0; i < len; i++) begin
      dws.push_back($urandom);
   end

   head = '0;
   head[fmt_msb:fmt_lsb]       = fmt;
   head[type_msb:type_lsb]     = tlp_type;
   head[41:32]                 = len[9:0];
   head[last_be_lsb +: be_w]   = last_be;
   head[first_be_lsb +: be_w]  = first_be;
   beats.push_back(head);
   // 3dw: address then first data dw, 4dw: upper then lower address dw
   if (is_4dw) begin
      beats.push_back({32'h0000_0001, addr});
      k = 0;
   end else begin
      beats.push_back({addr, dws[0]});
      k = 1;
   end
   single = 1'b0;
   while (k < len) begin
      if (k + 1 < len) begin
         beats.push_back({dws[k], dws[k+1]});
      end else begin
         filler = $urandom;
         beats.push_back({dws[k], filler});
         single = 1'b1;
      end
      k += 2;
   end

   // bar2 shifts the select by two, bar0 wins a double hit
   sel = {1'b0, addr[mem_sel_bit]};
   if (bar_hit_n[bar0_hit_idx]) begin
      sel = sel + bar2_mem_offset;
   end
   if (is_wr) begin
      exp_stat_cnt++;
      for (int i = 0; i < len; i++) begin
         mask = {be_w{1'b1}};
         if (i == len - 1) begin
            mask = last_be;
         end
         if (i == 0) begin
            mask = first_be;
         end
         push_expected(sel, addr + 32'(4 * i), dws[i], mask);
      end
   end

   last = beats.size() - 1;
   for (int j = 0; j <= last; j++) begin
      junk = {$urandom, $urandom};
      if (j > 0 && gap_mode == pause_gaps) begin
         drive_beat(junk, 1'b1, 1'b1, 8'h00, hit_none, 1'b0, 1'b0);
      end
      if (j > 0 && gap_mode == poison_gaps) begin
         drive_beat(junk, 1'b1, 1'b1, 8'h00, bar_hit_n, 1'b1, 1'b1);
      end
      rem_n = (j == last && single) ? 8'h0F : 8'h00;
      drive_beat(beats[j], j == 0, j == last, rem_n, bar_hit_n, 1'b1, 1'b0);
   end
endtask

`endif

// ==== tb_pcie_rx_wr.sv ====
/* testbench for the PCIe memory-write receive handler: clock, reset, DUT,
   lane scoreboards, directed tests and the result line */
module tb_pcie_rx_wr;
   timeunit 1ns;
   timeprecision 100ps;
   import pcie_wr_pkg::*;

   localparam int  addr_bits   = 12;
   localparam time drive_delay = 2ns;
   // tests take a few hundred cycles including reset and drain
   localparam int  max_cycles  = 2000;

   localparam logic [6:0] hit_bar0 = 7'b1111110;
   localparam logic [6:0] hit_bar2 = 7'b1111011;
   localparam logic [6:0] hit_none = 7'b1111111;

   // gaps inserted between the beats of one packet
   localparam int no_gaps     = 0;
   localparam int pause_gaps  = 1;
   localparam int poison_gaps = 2;

   typedef struct packed {
      logic [mem_sel_w-1:0] sel;
      logic [addr_bits-1:0] addr;
      logic [dw_w-1:0]      data;
      logic [be_w-1:0]      mask;
   } wr_rec_t;

   logic                  pcie_clk;
   logic                  rst;
   logic [trn_data_w-1:0] trn_rd;
   logic [7:0]            trn_rrem_n;
   logic                  trn_rsof_n;
   logic                  trn_reof_n;
   logic                  trn_rsrc_rdy_n;
   logic                  trn_rerrfwd_n;
   logic [6:0]            trn_rbar_hit_n;
   logic [mem_sel_w-1:0]  wr_mem_select;
   logic [addr_bits-1:0]  wr_addr_lo;
   logic [dw_w-1:0]       wr_data_lo;
   logic [be_w-1:0]       wr_mask_lo;
   logic                  wr_en_lo;
   logic [addr_bits-1:0]  wr_addr_hi;
   logic [dw_w-1:0]       wr_data_hi;
   logic [be_w-1:0]       wr_mask_hi;
   logic                  wr_en_hi;
   logic                  stat_pcie_rx_wr_cnt_inc;

   wr_rec_t lo_q[$];
   wr_rec_t hi_q[$];
   int      mismatch_cnt = 0;
   int      other_err_cnt = 0;
   int      stat_cnt = 0;
   int      exp_stat_cnt = 0;
   int      cycle_cnt = 0;

   pcie_rx_wr_top #(
      .MEM_ADDR_BITS (addr_bits)
   ) u_pcie_rx_wr_top (
      .trn_rd                  (trn_rd),
      .trn_rrem_n              (trn_rrem_n),
      .trn_rsof_n              (trn_rsof_n),
      .trn_reof_n              (trn_reof_n),
      .trn_rsrc_rdy_n          (trn_rsrc_rdy_n),
      .trn_rerrfwd_n           (trn_rerrfwd_n),
      .trn_rbar_hit_n          (trn_rbar_hit_n),
      .wr_mem_select           (wr_mem_select),
      .wr_addr_lo              (wr_addr_lo),
      .wr_data_lo              (wr_data_lo),
      .wr_mask_lo              (wr_mask_lo),
      .wr_en_lo                (wr_en_lo),
      .wr_addr_hi              (wr_addr_hi),
      .wr_data_hi              (wr_data_hi),
      .wr_mask_hi              (wr_mask_hi),
      .wr_en_hi                (wr_en_hi),
      .stat_pcie_rx_wr_cnt_inc (stat_pcie_rx_wr_cnt_inc),
      .pcie_clk                (pcie_clk),
      .rst                     (rst)
   );

   `include "tb_tlp_model.svh"

   initial begin
      pcie_clk = 1'b0;
      forever #10 pcie_clk = ~pcie_clk;
   end

   always @(posedge pcie_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == max_cycles) begin
         $display("timeout: run did not finish within %0d cycles", max_cycles);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // lane scoreboards sampled mid-cycle
   // ------------------------------------------------------------
   task automatic check_lane(input string lane, input logic hi_lane, input wr_rec_t got);
      wr_rec_t exp;
      int      depth;
      depth = hi_lane ? hi_q.size() : lo_q.size();
      assert (depth != 0) else begin
         other_err_cnt++;
         $display("unexpected write on the %s lane at %0d ns, addr %h", lane, $time, got.addr);
      end
      if (depth != 0) begin
         if (hi_lane) begin
            exp = hi_q.pop_front();
         end else begin
            exp = lo_q.pop_front();
         end
         assert (got == exp) else begin
            mismatch_cnt++;
            $display("MISMATCH at %0d ns: %s lane sel %0d addr %h data %h mask %h, %s",
                     $time, lane, got.sel, got.addr, got.data, got.mask,
                     $sformatf("expected sel %0d addr %h data %h mask %h",
                               exp.sel, exp.addr, exp.data, exp.mask));
         end
      end
   endtask

   always @(negedge pcie_clk) begin
      if (!rst) begin
         if (wr_en_lo) begin
            check_lane("lo", 1'b0, {wr_mem_select, wr_addr_lo, wr_data_lo, wr_mask_lo});
         end
         if (wr_en_hi) begin
            check_lane("hi", 1'b1, {wr_mem_select, wr_addr_hi, wr_data_hi, wr_mask_hi});
         end
         if (stat_pcie_rx_wr_cnt_inc) begin
            stat_cnt++;
         end
      end
   end

   // ------------------------------------------------------------
   // directed tests
   // ------------------------------------------------------------
   task automatic test_single_dw();
      send_tlp(fmt_3dw_wr, type_mem, hit_bar0, 32'h0000_0104, 1, 4'b0110, 4'b0000, no_gaps);
      idle_cycles(3);
      send_tlp(fmt_3dw_wr, type_mem, hit_bar0, 32'h0000_0230, 1, 4'b1000, 4'b0000, no_gaps);
      idle_cycles(3);
   endtask

   task automatic test_bar2_burst();
      send_tlp(fmt_3dw_wr, type_mem, hit_bar2, 32'h0000_1040, 5, 4'b1110, 4'b0011, no_gaps);
      idle_cycles(3);
      send_tlp(fmt_3dw_wr, type_mem, hit_bar2, 32'h0000_020c, 5, 4'b1100, 4'b0111, no_gaps);
      idle_cycles(3);
   endtask

   task automatic test_4dw();
      send_tlp(fmt_4dw_wr, type_mem, hit_bar0, 32'h0000_0324, 4, 4'b0001, 4'b1111, no_gaps);
      idle_cycles(3);
      send_tlp(fmt_4dw_wr, type_mem, hit_bar2, 32'h0000_1330, 4, 4'b1111, 4'b0001, no_gaps);
      idle_cycles(3);
      // odd length leaves one dw in the end beat
      send_tlp(fmt_4dw_wr, type_mem, hit_bar0, 32'h0000_0414, 3, 4'b1010, 4'b0101, no_gaps);
      idle_cycles(3);
   endtask

   task automatic test_dropped();
      send_tlp(fmt_3dw_wr, 5'b00100, hit_bar0, 32'h0000_0500, 2, 4'hF, 4'hF, no_gaps);
      idle_cycles(2);
      send_tlp(fmt_3dw_wr, type_mem, hit_none, 32'h0000_0600, 3, 4'hF, 4'hF, no_gaps);
      idle_cycles(2);
      send_tlp(fmt_3dw_wr, type_mem, hit_bar0, 32'h0000_0700, 2, 4'b0011, 4'b1100, no_gaps);
      idle_cycles(3);
   endtask

   task automatic test_gaps();
      send_tlp(fmt_3dw_wr, type_mem, hit_bar0, 32'h0000_0804, 6, 4'b1110, 4'b0001, pause_gaps);
      idle_cycles(3);
      send_tlp(fmt_4dw_wr, type_mem, hit_bar2, 32'h0000_0910, 5, 4'b0111, 4'b1110, poison_gaps);
      idle_cycles(3);
   endtask

   task automatic test_back_to_back();
      send_tlp(fmt_3dw_wr, type_mem, hit_bar0, 32'h0000_0a00, 1, 4'hF, 4'h0, no_gaps);
      send_tlp(fmt_4dw_wr, type_mem, hit_bar0, 32'h0000_0b0c, 2, 4'b1100, 4'b0011, no_gaps);
      send_tlp(fmt_3dw_wr, type_mem, hit_bar2, 32'h0000_1c04, 3, 4'b0110, 4'b1001, no_gaps);
      send_tlp(fmt_3dw_wr, type_mem, hit_bar2, 32'h0000_0d08, 4, 4'hF, 4'hF, no_gaps);
      idle_cycles(3);
   endtask

   // wait for the pipeline to empty, then a few more cycles for stray writes
   task automatic wait_drain();
      int n;
      n = 0;
      while ((lo_q.size() != 0 || hi_q.size() != 0) && n < 20) begin
         @(posedge pcie_clk);
         n++;
      end
      repeat (4) @(posedge pcie_clk);
      #drive_delay;
   endtask

   initial begin
      void'($urandom(6291));
      rst            = 1'b1;
      trn_rd         = '0;
      trn_rrem_n     = '0;
      trn_rsof_n     = 1'b1;
      trn_reof_n     = 1'b1;
      trn_rsrc_rdy_n = 1'b1;
      trn_rerrfwd_n  = 1'b1;
      trn_rbar_hit_n = hit_none;
      repeat (10) @(posedge pcie_clk);
      #drive_delay;
      rst = 1'b0;
      idle_cycles(2);

      test_single_dw();
      test_bar2_burst();
      test_4dw();
      test_dropped();
      test_gaps();
      test_back_to_back();
      wait_drain();

      assert (lo_q.size() == 0 && hi_q.size() == 0) else begin
         other_err_cnt++;
         $display("missing writes: %0d lo and %0d hi never appeared", lo_q.size(), hi_q.size());
      end
      assert (stat_cnt == exp_stat_cnt) else begin
         mismatch_cnt++;
         $display("MISMATCH at %0d ns: stat pulse count %0d, expected %0d",
                  $time, stat_cnt, exp_stat_cnt);
      end
      $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_err_cnt);
      if (mismatch_cnt == 0 && other_err_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== pcie_rx_wr_top.sv ====
/* receive-side memory-write handler: input register, packet FSM, lane steering */
module pcie_rx_wr_top #(
   parameter int MEM_ADDR_BITS = 12
) (
   input  logic [pcie_wr_pkg::trn_data_w-1:0] trn_rd,
   input  logic [7:0]                        trn_rrem_n,
   input  logic                              trn_rsof_n,
   input  logic                              trn_reof_n,
   input  logic                              trn_rsrc_rdy_n,
   input  logic                              trn_rerrfwd_n,
   input  logic [6:0]                        trn_rbar_hit_n,
   output logic [pcie_wr_pkg::mem_sel_w-1:0]  wr_mem_select,
   output logic [MEM_ADDR_BITS-1:0]          wr_addr_lo,
   output logic [pcie_wr_pkg::dw_w-1:0]       wr_data_lo,
   output logic [pcie_wr_pkg::be_w-1:0]       wr_mask_lo,
   output logic                              wr_en_lo,
   output logic [MEM_ADDR_BITS-1:0]          wr_addr_hi,
   output logic [pcie_wr_pkg::dw_w-1:0]       wr_data_hi,
   output logic [pcie_wr_pkg::be_w-1:0]       wr_mask_hi,
   output logic                              wr_en_hi,
   output logic                              stat_pcie_rx_wr_cnt_inc,
   input  logic                              pcie_clk,
   input  logic                              rst
);
   import pcie_wr_pkg::*;

   // registered receive beat
   logic [trn_data_w-1:0]    beat_data;
   logic [7:0]               beat_rem_n;
   logic                     beat_sof;
   logic                     beat_eof;
   logic                     beat_valid;
   logic [6:0]               beat_bar_hit_n;

   // doubleword commands
   logic [mem_sel_w-1:0]     cmd_mem_sel;
   logic [MEM_ADDR_BITS-1:0] cmd_addr;
   logic                     cmd_dw0_valid;
   logic [dw_w-1:0]          cmd_dw0_data;
   logic [be_w-1:0]          cmd_dw0_mask;
   logic                     cmd_dw1_valid;
   logic [dw_w-1:0]          cmd_dw1_data;
   logic [be_w-1:0]          cmd_dw1_mask;
   logic                     cmd_new_req;

   rx_in_reg u_rx_in_reg (
      .pcie_clk       (pcie_clk),
      .rst            (rst),
      .trn_rd         (trn_rd),
      .trn_rrem_n     (trn_rrem_n),
      .trn_rsof_n     (trn_rsof_n),
      .trn_reof_n     (trn_reof_n),
      .trn_rsrc_rdy_n (trn_rsrc_rdy_n),
      .trn_rerrfwd_n  (trn_rerrfwd_n),
      .trn_rbar_hit_n (trn_rbar_hit_n),
      .beat_data      (beat_data),
      .beat_rem_n     (beat_rem_n),
      .beat_sof       (beat_sof),
      .beat_eof       (beat_eof),
      .beat_valid     (beat_valid),
      .beat_bar_hit_n (beat_bar_hit_n)
   );

   tlp_wr_fsm #(
      .MEM_ADDR_BITS (MEM_ADDR_BITS)
   ) u_tlp_wr_fsm (
      .pcie_clk       (pcie_clk),
      .rst            (rst),
      .beat_data      (beat_data),
      .beat_rem_n     (beat_rem_n),
      .beat_sof       (beat_sof),
      .beat_eof       (beat_eof),
      .beat_valid     (beat_valid),
      .beat_bar_hit_n (beat_bar_hit_n),
      .cmd_mem_sel    (cmd_mem_sel),
      .cmd_addr       (cmd_addr),
      .cmd_dw0_valid  (cmd_dw0_valid),
      .cmd_dw0_data   (cmd_dw0_data),
      .cmd_dw0_mask   (cmd_dw0_mask),
      .cmd_dw1_valid  (cmd_dw1_valid),
      .cmd_dw1_data   (cmd_dw1_data),
      .cmd_dw1_mask   (cmd_dw1_mask),
      .cmd_new_req    (cmd_new_req)
   );

   wr_lane_steer #(
      .MEM_ADDR_BITS (MEM_ADDR_BITS)
   ) u_wr_lane_steer (
      .pcie_clk                (pcie_clk),
      .rst                     (rst),
      .cmd_mem_sel             (cmd_mem_sel),
      .cmd_addr                (cmd_addr),
      .cmd_dw0_valid           (cmd_dw0_valid),
      .cmd_dw0_data            (cmd_dw0_data),
      .cmd_dw0_mask            (cmd_dw0_mask),
      .cmd_dw1_valid           (cmd_dw1_valid),
      .cmd_dw1_data            (cmd_dw1_data),
      .cmd_dw1_mask            (cmd_dw1_mask),
      .cmd_new_req             (cmd_new_req),
      .wr_mem_select           (wr_mem_select),
      .wr_addr_lo              (wr_addr_lo),
      .wr_data_lo              (wr_data_lo),
      .wr_mask_lo              (wr_mask_lo),
      .wr_en_lo                (wr_en_lo),
      .wr_addr_hi              (wr_addr_hi),
      .wr_data_hi              (wr_data_hi),
      .wr_mask_hi              (wr_mask_hi),
      .wr_en_hi                (wr_en_hi),
      .stat_pcie_rx_wr_cnt_inc (stat_pcie_rx_wr_cnt_inc)
   );

endmodule

// ==== wr_lane_steer.sv ====
/* byte swap and lo/hi lane routing of doubleword commands, registered memory
   write outputs and stat pulse */
module wr_lane_steer #(
   parameter int MEM_ADDR_BITS = 12
) (
   input  logic                             pcie_clk,
   input  logic                             rst,
   input  logic [pcie_wr_pkg::mem_sel_w-1:0] cmd_mem_sel,
   input  logic [MEM_ADDR_BITS-1:0]         cmd_addr,
   input  logic                             cmd_dw0_valid,
   input  logic [pcie_wr_pkg::dw_w-1:0]      cmd_dw0_data,
   input  logic [pcie_wr_pkg::be_w-1:0]      cmd_dw0_mask,
   input  logic                             cmd_dw1_valid,
   input  logic [pcie_wr_pkg::dw_w-1:0]      cmd_dw1_data,
   input  logic [pcie_wr_pkg::be_w-1:0]      cmd_dw1_mask,
   input  logic                             cmd_new_req,
   output logic [pcie_wr_pkg::mem_sel_w-1:0] wr_mem_select,
   output logic [MEM_ADDR_BITS-1:0]         wr_addr_lo,
   output logic [pcie_wr_pkg::dw_w-1:0]      wr_data_lo,
   output logic [pcie_wr_pkg::be_w-1:0]      wr_mask_lo,
   output logic                             wr_en_lo,
   output logic [MEM_ADDR_BITS-1:0]         wr_addr_hi,
   output logic [pcie_wr_pkg::dw_w-1:0]      wr_data_hi,
   output logic [pcie_wr_pkg::be_w-1:0]      wr_mask_hi,
   output logic                             wr_en_hi,
   output logic                             stat_pcie_rx_wr_cnt_inc
);
   import pcie_wr_pkg::*;

   logic [MEM_ADDR_BITS-1:0] dw1_addr;
   logic                     dw0_hi;

   // TLP payload is big endian on the wire
   function automatic logic [dw_w-1:0] byte_swap(input logic [dw_w-1:0] d);
      return {d[7:0], d[15:8], d[23:16], d[31:24]};
   endfunction

   assign dw1_addr = cmd_addr + MEM_ADDR_BITS'(4);
   // dw1 always lands on the other lane
   assign dw0_hi   = cmd_addr[2];

   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         wr_en_lo                <= 1'b0;
         wr_en_hi                <= 1'b0;
         stat_pcie_rx_wr_cnt_inc <= 1'b0;
      end else begin
         wr_en_lo                <= dw0_hi ? cmd_dw1_valid : cmd_dw0_valid;
         wr_en_hi                <= dw0_hi ? cmd_dw0_valid : cmd_dw1_valid;
         stat_pcie_rx_wr_cnt_inc <= cmd_new_req;
      end
   end

   always_ff @(posedge pcie_clk) begin
      wr_mem_select <= cmd_mem_sel;
      if (dw0_hi) begin
         wr_addr_hi <= cmd_addr;
         wr_data_hi <= byte_swap(cmd_dw0_data);
         wr_mask_hi <= cmd_dw0_mask;
         wr_addr_lo <= dw1_addr;
         wr_data_lo <= byte_swap(cmd_dw1_data);
         wr_mask_lo <= cmd_dw1_mask;
      end else begin
         wr_addr_lo <= cmd_addr;
         wr_data_lo <= byte_swap(cmd_dw0_data);
         wr_mask_lo <= cmd_dw0_mask;
         wr_addr_hi <= dw1_addr;
         wr_data_hi <= byte_swap(cmd_dw1_data);
         wr_mask_hi <= cmd_dw1_mask;
      end
   end

   // ------------------------------------------------------------
   // checks on the memory side
   // ------------------------------------------------------------
   a_lane_addr_bit: assert property (@(posedge pcie_clk) disable iff (rst)
      (!wr_en_hi || wr_addr_hi[2]) && (!wr_en_lo || !wr_addr_lo[2]));

   // a paired write covers two adjacent doublewords, never one slot twice
   a_pair_adjacent: assert property (@(posedge pcie_clk) disable iff (rst)
      (wr_en_lo && wr_en_hi) |->
         (wr_addr_hi == wr_addr_lo + MEM_ADDR_BITS'(4)) ||
         (wr_addr_lo == wr_addr_hi + MEM_ADDR_BITS'(4)));

endmodule

// ==== tlp_wr_fsm.sv ====
/* packet FSM for memory-write TLPs: running address, first/last dw tracking
   and per-beat doubleword commands */
module tlp_wr_fsm #(
   parameter int MEM_ADDR_BITS = 12
) (
   input  logic                              pcie_clk,
   input  logic                              rst,
   input  logic [pcie_wr_pkg::trn_data_w-1:0] beat_data,
   input  logic [7:0]                        beat_rem_n,
   input  logic                              beat_sof,
   input  logic                              beat_eof,
   input  logic                              beat_valid,
   input  logic [6:0]                        beat_bar_hit_n,
   output logic [pcie_wr_pkg::mem_sel_w-1:0]  cmd_mem_sel,
   output logic [MEM_ADDR_BITS-1:0]          cmd_addr,
   output logic                              cmd_dw0_valid,
   output logic [pcie_wr_pkg::dw_w-1:0]       cmd_dw0_data,
   output logic [pcie_wr_pkg::be_w-1:0]       cmd_dw0_mask,
   output logic                              cmd_dw1_valid,
   output logic [pcie_wr_pkg::dw_w-1:0]       cmd_dw1_data,
   output logic [pcie_wr_pkg::be_w-1:0]       cmd_dw1_mask,
   output logic                              cmd_new_req
);
   import pcie_wr_pkg::*;

   localparam logic [be_w-1:0] all_bytes = '1;

   rx_state_e                state;
   req_op_e                  op;
   logic                     first_dw;
   logic [trn_data_w-1:0]    head1;
   logic [mem_sel_w-1:0]     mem_sel;
   logic [be_w-1:0]          last_be;
   logic [MEM_ADDR_BITS-1:0] addr;

   req_op_e                  req_op;
   logic                     req_4dw;
   logic [mem_sel_w-1:0]     req_mem_sel;
   logic [MEM_ADDR_BITS-1:0] req_addr;
   logic [be_w-1:0]          req_first_be;
   logic [be_w-1:0]          req_last_be;

   tlp_hdr_decode #(
      .MEM_ADDR_BITS (MEM_ADDR_BITS)
   ) u_hdr_decode (
      .head1          (head1),
      .beat_data      (beat_data),
      .beat_bar_hit_n (beat_bar_hit_n),
      .req_op         (req_op),
      .req_4dw        (req_4dw),
      .req_mem_sel    (req_mem_sel),
      .req_addr       (req_addr),
      .req_first_be   (req_first_be),
      .req_last_be    (req_last_be)
   );

   // ------------------------------------------------------------
   // state and request control
   // ------------------------------------------------------------
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         state    <= wait_sof;
         op       <= op_drop;
         first_dw <= 1'b0;
      end else if (beat_valid) begin
         case (state)
            wait_sof: begin
               if (beat_sof) begin
                  state <= header2;
               end
            end
            header2: begin
               op       <= req_op;
               // 4dw data starts in the first body beat
               first_dw <= req_4dw;
               state    <= beat_eof ? wait_sof : body;
            end
            body: begin
               first_dw <= 1'b0;
               if (beat_eof) begin
                  state <= wait_sof;
               end
            end
            default: state <= wait_sof;
         endcase
      end
   end

   // header and address bookkeeping
   always_ff @(posedge pcie_clk) begin
      if (beat_valid) begin
         if (state == wait_sof && beat_sof) begin
            head1 <= beat_data;
         end
         if (state == header2) begin
            mem_sel <= req_mem_sel;
            last_be <= req_last_be;
            addr    <= req_4dw ? req_addr : req_addr + MEM_ADDR_BITS'(4);
         end
         if (state == body) begin
            addr <= addr + MEM_ADDR_BITS'(8);
         end
      end
   end

   // ------------------------------------------------------------
   // per-beat commands
   // ------------------------------------------------------------
   always_comb begin
      cmd_mem_sel   = mem_sel;
      cmd_addr      = addr;
      cmd_dw0_valid = 1'b0;
      cmd_dw0_data  = beat_data[trn_data_w-1:dw_w];
      cmd_dw0_mask  = all_bytes;
      cmd_dw1_valid = 1'b0;
      cmd_dw1_data  = beat_data[dw_w-1:0];
      cmd_dw1_mask  = all_bytes;
      cmd_new_req   = 1'b0;
      if (beat_valid && state == header2 && req_op == op_write) begin
         cmd_new_req = 1'b1;
         cmd_mem_sel = req_mem_sel;
         cmd_addr    = req_addr;
         // 3dw carries the first data dw next to the address
         if (!req_4dw) begin
            cmd_dw0_valid = 1'b1;
            cmd_dw0_data  = beat_data[dw_w-1:0];
            cmd_dw0_mask  = req_first_be;
         end
      end else if (beat_valid && state == body && op == op_write) begin
         cmd_dw0_valid = 1'b1;
         cmd_dw1_valid = !beat_eof || (beat_rem_n[3:0] == 4'h0);
         if (first_dw) begin
            cmd_dw0_mask = req_first_be;
         end else if (beat_eof && !cmd_dw1_valid) begin
            cmd_dw0_mask = last_be;
         end
         if (beat_eof) begin
            cmd_dw1_mask = last_be;
         end
      end
   end

   a_state_legal: assert property (@(posedge pcie_clk) disable iff (rst)
      state inside {wait_sof, header2, body});

endmodule

// ==== tlp_hdr_decode.sv ====
/* combinational decode of the two header beats of a memory write:
   request class, memory select, start address and byte enables */
module tlp_hdr_decode #(
   parameter int MEM_ADDR_BITS = 12
) (
   input  logic [pcie_wr_pkg::trn_data_w-1:0] head1,
   input  logic [pcie_wr_pkg::trn_data_w-1:0] beat_data,
   input  logic [6:0]                        beat_bar_hit_n,
   output pcie_wr_pkg::req_op_e              req_op,
   output logic                              req_4dw,
   output logic [pcie_wr_pkg::mem_sel_w-1:0]  req_mem_sel,
   output logic [MEM_ADDR_BITS-1:0]          req_addr,
   output logic [pcie_wr_pkg::be_w-1:0]       req_first_be,
   output logic [pcie_wr_pkg::be_w-1:0]       req_last_be
);
   import pcie_wr_pkg::*;

   logic [fmt_msb-fmt_lsb:0]   fmt;
   logic [type_msb-type_lsb:0] tlp_type;
   logic                       is_3dw;
   logic                       is_4dw;
   logic                       bar0_hit;
   logic                       bar2_hit;
   logic [dw_w-1:0]            addr_dw;

   assign fmt      = head1[fmt_msb:fmt_lsb];
   assign tlp_type = head1[type_msb:type_lsb];

   assign is_3dw  = (fmt == fmt_3dw_wr) && (tlp_type == type_mem);
   assign is_4dw  = (fmt == fmt_4dw_wr) && (tlp_type == type_mem);
   assign req_4dw = is_4dw;

   // 3dw: address sits in the upper half, 4dw: low address dw in the lower half
   assign addr_dw  = is_4dw ? beat_data[dw_w-1:0] : beat_data[trn_data_w-1:dw_w];
   assign req_addr = addr_dw[MEM_ADDR_BITS-1:0];

   assign bar0_hit = ~beat_bar_hit_n[bar0_hit_idx];
   assign bar2_hit = ~beat_bar_hit_n[bar2_hit_idx];

   // bar0 wins if both hit
   always_comb begin
      req_mem_sel = {{(mem_sel_w-1){1'b0}}, addr_dw[mem_sel_bit]};
      if (!bar0_hit && bar2_hit) begin
         req_mem_sel = req_mem_sel + bar2_mem_offset;
      end
   end

   always_comb begin
      if ((is_3dw || is_4dw) && (bar0_hit || bar2_hit)) begin
         req_op = op_write;
      end else begin
         req_op = op_drop;
      end
   end

   assign req_first_be = head1[first_be_lsb +: be_w];
   assign req_last_be  = head1[last_be_lsb +: be_w];

endmodule

// ==== rx_in_reg.sv ====
/* input register stage for the transaction receive bus */
module rx_in_reg (
   input  logic                              pcie_clk,
   input  logic                              rst,
   input  logic [pcie_wr_pkg::trn_data_w-1:0] trn_rd,
   input  logic [7:0]                        trn_rrem_n,
   input  logic                              trn_rsof_n,
   input  logic                              trn_reof_n,
   input  logic                              trn_rsrc_rdy_n,
   input  logic                              trn_rerrfwd_n,
   input  logic [6:0]                        trn_rbar_hit_n,
   output logic [pcie_wr_pkg::trn_data_w-1:0] beat_data,
   output logic [7:0]                        beat_rem_n,
   output logic                              beat_sof,
   output logic                              beat_eof,
   output logic                              beat_valid,
   output logic [6:0]                        beat_bar_hit_n
);

   // beat is usable only when the source is ready and nothing was poisoned
   always_ff @(posedge pcie_clk) begin
      if (rst) begin
         beat_valid <= 1'b0;
      end else begin
         beat_valid <= ~trn_rsrc_rdy_n & trn_rerrfwd_n;
      end
   end

   // payload and framing, qualified later by beat_valid
   always_ff @(posedge pcie_clk) begin
      beat_data      <= trn_rd;
      beat_rem_n     <= trn_rrem_n;
      beat_sof       <= ~trn_rsof_n;
      beat_eof       <= ~trn_reof_n;
      beat_bar_hit_n <= trn_rbar_hit_n;
   end

endmodule

// ==== pcie_wr_pkg.sv ====
/* widths, TLP header and BAR field positions, FSM state and request op enums
   shared by the PCIe memory-write receive path */
package pcie_wr_pkg;

   // bus and lane widths
   localparam int trn_data_w = 64;
   localparam int dw_w       = 32;
   localparam int be_w       = 4;
   localparam int mem_sel_w  = 2;

   // ------------------------------------------------------------
   // header beat 1 fields
   // ------------------------------------------------------------
   localparam int fmt_msb      = 62;
   localparam int fmt_lsb      = 61;
   localparam int type_msb     = 60;
   localparam int type_lsb     = 56;
   localparam int first_be_lsb = 0;
   localparam int last_be_lsb  = 4;

   localparam logic [1:0] fmt_3dw_wr = 2'b10;
   localparam logic [1:0] fmt_4dw_wr = 2'b11;
   localparam logic [4:0] type_mem   = 5'b00000;

   // ------------------------------------------------------------
   // BAR decode
   // ------------------------------------------------------------
   localparam int                   mem_sel_bit     = 12;
   localparam logic [mem_sel_w-1:0] bar2_mem_offset = 2'd2;
   localparam int                   bar0_hit_idx    = 0;
   localparam int                   bar2_hit_idx    = 2;

   typedef enum logic [1:0] {wait_sof, header2, body} rx_state_e;
   typedef enum logic {op_write, op_drop} req_op_e;

endpackage
